//--- source/idecode_params.svh
// widths, reset values and register bit positions of the decode stage
// included by the package and by every module that sizes a port

`ifndef IDECODE_PARAMS_SVH
`define IDECODE_PARAMS_SVH

// datapath widths
`define IDECODE_INST_W      8
`define IDECODE_ADDR_W      12
`define IDECODE_REG_SEL_W   2
`define IDECODE_CR_W        8

// control register, branch condition bits
`define IDECODE_CR_BCZ_BIT  0
`define IDECODE_CR_BCNZ_BIT 1

// status register flags seen by JMP
`define IDECODE_SR_NZ_BIT   2
`define IDECODE_SR_Z_BIT    3

`define IDECODE_CR_RESET    8'h00

// cycles of fetch hold-off after RET
`define IDECODE_RET_WINDOW  2

`endif

//--- source/idecode_pkg.sv
// instruction formats, execute operations and the execute command
// shared by all decode stage modules

`include "idecode_params.svh"

package idecode_pkg;

    typedef enum logic [2:0] {
        BASE_CTRL = 3'b000,
        BASE_ADD  = 3'b001,
        BASE_SUB  = 3'b010,
        BASE_AND  = 3'b011,
        BASE_OR   = 3'b100,
        BASE_XOR  = 3'b101,
        BASE_LD   = 3'b110,
        BASE_ST   = 3'b111
    } base_op_t;

    // sub-op of the control group
    typedef enum logic [1:0] {
        SUB_MISC = 2'b00,
        SUB_USR  = 2'b01,   // unimplemented, illegal
        SUB_JMP  = 2'b10,
        SUB_CALL = 2'b11
    } ctl_sub_t;

    // low field when the sub-op is MISC, 6 and 7 are illegal
    typedef enum logic [2:0] {
        MISC_NOP      = 3'd0,
        MISC_RET      = 3'd1,
        MISC_HALT     = 3'd2,
        MISC_SET_BCZ  = 3'd3,
        MISC_SET_BCNZ = 3'd4,
        MISC_CLR_BC   = 3'd5
    } misc_cmd_t;

    typedef struct packed {
        base_op_t                      base_op;
        logic                          imm;     // second byte is an immediate
        logic [`IDECODE_REG_SEL_W-1:0] ptr0;
        logic [`IDECODE_REG_SEL_W-1:0] ptr1;
    } alu_fmt_t;

    typedef struct packed {
        base_op_t   base_op;
        ctl_sub_t   sub_op;     // also the LD/ST register selector
        logic [2:0] low;        // misc command or address bits 10:8
    } ctl_fmt_t;

    typedef union packed {
        alu_fmt_t alu_fmt;
        ctl_fmt_t ctl_fmt;
    } inst_u;

    localparam logic [`IDECODE_INST_W-1:0] NOP_INST = 8'h00;

    typedef enum logic [3:0] {
        EXEC_NOP, EXEC_ADD, EXEC_SUB, EXEC_AND, EXEC_OR, EXEC_XOR,
        EXEC_MEM_RD, EXEC_MEM_WR, EXEC_JMP, EXEC_CALL, EXEC_RET
    } exec_op_t;

    // branch condition update request to the control register
    typedef enum logic [1:0] {
        BC_NONE, BC_SET_BCZ, BC_SET_BCNZ, BC_CLR
    } bc_cmd_t;

    typedef struct packed {
        logic [`IDECODE_REG_SEL_W-1:0] src0;
        logic                          src0_rd_en;
        logic [`IDECODE_REG_SEL_W-1:0] src1;
        logic                          src1_rd_en;
        logic [`IDECODE_REG_SEL_W-1:0] dst;
    } operand_sel_t;

    typedef struct packed {
        exec_op_t                      op;
        logic [`IDECODE_REG_SEL_W-1:0] src0;
        logic                          src0_rd_en;
        logic [`IDECODE_REG_SEL_W-1:0] src1;
        logic                          src1_rd_en;
        logic [`IDECODE_REG_SEL_W-1:0] dst;
        logic [`IDECODE_INST_W-1:0]    imm_val;
        logic                          imm_vld;
        logic [`IDECODE_ADDR_W-1:0]    addr;
    } exec_cmd_t;

endpackage

//--- source/decode_ctrl.sv
// sequencing control of the decode stage
// tracks two-byte instructions, halt and the RET window, and picks the execute op

`include "idecode_params.svh"

module decode_ctrl (
    input  logic                       clk,
    input  logic                       reset_,
    input  logic                       decode_en,
    input  logic [`IDECODE_INST_W-1:0] inst,
    input  logic                       branch_taken,
    output idecode_pkg::inst_u         cur_inst,
    output idecode_pkg::inst_u         prev_inst,
    output logic                       second_byte,
    output logic                       first_byte,
    output idecode_pkg::exec_op_t      exec_op_next,
    output logic                       exec_en,
    output logic                       fetch_en,
    output logic                       latch_ret_addr,
    output logic                       halted,
    output idecode_pkg::bc_cmd_t       bc_cmd
);
    import idecode_pkg::*;

    logic                           byte2_pend;     // waiting for the second byte
    logic [`IDECODE_RET_WINDOW-1:0] ret_sr;
    logic                           ret_active;
    logic                           accept;
    logic                           two_byte;
    logic                           is_ctrl;
    logic                           is_misc;
    logic                           is_ret;
    logic                           is_halt;
    logic                           illegal;

    assign ret_active = |ret_sr;
    assign cur_inst   = ret_active ? NOP_INST : inst;  // restore window decodes as NOP

    assign accept      = decode_en && !halted;
    assign first_byte  = accept && !byte2_pend;
    assign second_byte = accept && byte2_pend;

    assign is_ctrl = cur_inst.ctl_fmt.base_op == BASE_CTRL;
    assign is_misc = is_ctrl && cur_inst.ctl_fmt.sub_op == SUB_MISC;
    assign is_ret  = is_misc && cur_inst.ctl_fmt.low == MISC_RET;
    assign is_halt = is_misc && cur_inst.ctl_fmt.low == MISC_HALT;
    assign illegal = is_ctrl && (cur_inst.ctl_fmt.sub_op == SUB_USR ||
                                 (is_misc && cur_inst.ctl_fmt.low > MISC_CLR_BC));

    assign latch_ret_addr = first_byte && is_ctrl && cur_inst.ctl_fmt.sub_op == SUB_CALL;
    assign fetch_en       = !halted && !ret_active;

    always_comb begin
        case (cur_inst.alu_fmt.base_op)
            BASE_CTRL:        two_byte = cur_inst.ctl_fmt.sub_op inside {SUB_JMP, SUB_CALL};
            BASE_LD, BASE_ST: two_byte = 1'b1;  // address byte follows
            default:          two_byte = cur_inst.alu_fmt.imm;
        endcase
    end

    // second bytes and idle cycles give NOP
    always_comb begin
        exec_op_next = EXEC_NOP;
        if (first_byte) begin
            case (cur_inst.alu_fmt.base_op)
                BASE_ADD: exec_op_next = EXEC_ADD;
                BASE_SUB: exec_op_next = EXEC_SUB;
                BASE_AND: exec_op_next = EXEC_AND;
                BASE_OR:  exec_op_next = EXEC_OR;
                BASE_XOR: exec_op_next = EXEC_XOR;
                BASE_LD:  exec_op_next = EXEC_MEM_RD;
                BASE_ST:  exec_op_next = EXEC_MEM_WR;
                BASE_CTRL: begin
                    case (cur_inst.ctl_fmt.sub_op)
                        SUB_JMP:  exec_op_next = branch_taken ? EXEC_JMP : EXEC_NOP;
                        SUB_CALL: exec_op_next = EXEC_CALL;
                        SUB_MISC: exec_op_next = is_ret ? EXEC_RET : EXEC_NOP;
                        default:  exec_op_next = EXEC_NOP;
                    endcase
                end
                default: exec_op_next = EXEC_NOP;
            endcase
        end
    end

    always_comb begin
        bc_cmd = BC_NONE;
        if (first_byte && is_misc) begin
            case (cur_inst.ctl_fmt.low)
                MISC_SET_BCZ:  bc_cmd = BC_SET_BCZ;
                MISC_SET_BCNZ: bc_cmd = BC_SET_BCNZ;
                MISC_CLR_BC:   bc_cmd = BC_CLR;
                default:       bc_cmd = BC_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            byte2_pend <= 1'b0;
            ret_sr     <= '0;
            halted     <= 1'b0;
            exec_en    <= 1'b0;
        end else begin
            if (first_byte) begin
                byte2_pend <= two_byte;
            end else if (second_byte) begin
                byte2_pend <= 1'b0;
            end
            ret_sr  <= {ret_sr[`IDECODE_RET_WINDOW-2:0], first_byte && is_ret};
            halted  <= halted || (first_byte && is_halt);  // sticky
            exec_en <= first_byte && !is_halt;
        end
    end

    // first byte kept for the second byte decode
    always_ff @(posedge clk) begin
        if (first_byte) begin
            prev_inst <= cur_inst;
        end
    end

    a_no_illegal: assert property (@(posedge clk) disable iff (!reset_)
        first_byte |-> !illegal)
        else $error("illegal instruction byte %02h", cur_inst);

    a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_)
        halted |=> halted);

endmodule

//--- source/operand_decode.sv
// register selectors and immediate value of the execute command
// selectors come from the first byte, the immediate from the second

`include "idecode_params.svh"

module operand_decode (
    input  logic                        clk,
    input  logic                        reset_,
    input  idecode_pkg::inst_u          cur_inst,
    input  idecode_pkg::inst_u          prev_inst,
    input  logic                        second_byte,
    input  logic                        first_byte,
    output idecode_pkg::operand_sel_t   sel,
    output logic [`IDECODE_INST_W-1:0]  imm_val,
    output logic                        imm_vld
);
    import idecode_pkg::*;

    operand_sel_t sel_next;
    logic         imm_cap;  // second byte is data, not an address

    assign imm_cap = second_byte &&
                     !(prev_inst.alu_fmt.base_op inside {BASE_LD, BASE_ST});

    always_comb begin
        sel_next            = sel;
        sel_next.src0_rd_en = 1'b0;  // read enables last one cycle
        sel_next.src1_rd_en = 1'b0;
        if (first_byte) begin
            case (cur_inst.alu_fmt.base_op)
                BASE_ADD, BASE_SUB, BASE_AND, BASE_OR, BASE_XOR: begin
                    sel_next.src0       = cur_inst.alu_fmt.ptr0;
                    sel_next.src0_rd_en = 1'b1;
                    sel_next.dst        = cur_inst.alu_fmt.ptr1;
                    if (!cur_inst.alu_fmt.imm) begin
                        sel_next.src1       = cur_inst.alu_fmt.ptr1;
                        sel_next.src1_rd_en = 1'b1;
                    end
                end
                BASE_LD: begin
                    sel_next.dst = cur_inst.ctl_fmt.sub_op;  // load target
                end
                BASE_ST: begin
                    sel_next.src0       = cur_inst.ctl_fmt.sub_op;  // store data
                    sel_next.src0_rd_en = 1'b1;
                end
                default: begin
                    // control group reads no registers
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            sel     <= '0;
            imm_val <= '0;
            imm_vld <= 1'b0;
        end else begin
            sel <= sel_next;
            if (imm_cap) begin
                imm_val <= cur_inst;
            end
            if (second_byte) begin
                imm_vld <= 1'b1;
            end else if (first_byte) begin
                imm_vld <= 1'b0;
            end
        end
    end

    // register and immediate forms never overlap
    a_src1_vs_imm: assert property (@(posedge clk) disable iff (!reset_)
        !(sel.src1_rd_en && imm_vld));

endmodule

//--- source/addr_assemble.sv
// memory and branch address from the low bits of the first byte and the second byte
// tgt_addr shows it in the cycle of the second byte, addr holds it registered

`include "idecode_params.svh"

module addr_assemble (
    input  logic                       clk,
    input  logic                       reset_,
    input  idecode_pkg::inst_u         cur_inst,
    input  idecode_pkg::inst_u         prev_inst,
    input  logic                       second_byte,
    output logic [`IDECODE_ADDR_W-1:0] addr,
    output logic [`IDECODE_ADDR_W-1:0] tgt_addr
);
    import idecode_pkg::*;

    logic                       addr_op;
    logic [`IDECODE_ADDR_W-1:0] addr_next;

    always_comb begin
        case (prev_inst.ctl_fmt.base_op)
            BASE_LD, BASE_ST: addr_op = 1'b1;
            BASE_CTRL:        addr_op = prev_inst.ctl_fmt.sub_op inside {SUB_JMP, SUB_CALL};
            default:          addr_op = 1'b0;  // alu immediate
        endcase
    end

    // zero extended 11-bit direct address
    assign addr_next = {{(`IDECODE_ADDR_W - `IDECODE_INST_W - 3){1'b0}},
                        prev_inst.ctl_fmt.low, cur_inst};

    assign tgt_addr = (second_byte && addr_op) ? addr_next : addr;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            addr <= '0;
        end else if (second_byte && addr_op) begin
            addr <= addr_next;
        end
    end

endmodule

//--- source/ctrl_reg.sv
// control register with the branch condition bits
// external write first, then the decoded bc command on top

`include "idecode_params.svh"

module ctrl_reg (
    input  logic                     clk,
    input  logic                     reset_,
    input  logic [`IDECODE_CR_W-1:0] cr_wr_data,
    input  logic                     cr_wr_en,
    input  idecode_pkg::bc_cmd_t     bc_cmd,
    input  logic [`IDECODE_CR_W-1:0] sr,
    output logic [`IDECODE_CR_W-1:0] cr,
    output logic                     branch_taken
);
    import idecode_pkg::*;

    logic [`IDECODE_CR_W-1:0] cr_next;

    always_comb begin
        cr_next = cr_wr_en ? cr_wr_data : cr;
        case (bc_cmd)
            BC_SET_BCZ: begin
                cr_next[`IDECODE_CR_BCZ_BIT]  = 1'b1;
                cr_next[`IDECODE_CR_BCNZ_BIT] = 1'b0;
            end
            BC_SET_BCNZ: begin
                cr_next[`IDECODE_CR_BCZ_BIT]  = 1'b0;
                cr_next[`IDECODE_CR_BCNZ_BIT] = 1'b1;
            end
            BC_CLR: begin
                cr_next[`IDECODE_CR_BCZ_BIT]  = 1'b0;
                cr_next[`IDECODE_CR_BCNZ_BIT] = 1'b0;
            end
            default: begin
                // keep written or held value
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            cr <= `IDECODE_CR_RESET;
        end else begin
            cr <= cr_next;
        end
    end

    // no condition bit means unconditional
    assign branch_taken =
        !(cr[`IDECODE_CR_BCZ_BIT] || cr[`IDECODE_CR_BCNZ_BIT]) ||
        (cr[`IDECODE_CR_BCNZ_BIT] && sr[`IDECODE_SR_NZ_BIT]) ||
        (cr[`IDECODE_CR_BCZ_BIT] && sr[`IDECODE_SR_Z_BIT]);

    a_bc_exclusive: assert property (@(posedge clk) disable iff (!reset_)
        bc_cmd != BC_NONE |=> !(cr[`IDECODE_CR_BCZ_BIT] && cr[`IDECODE_CR_BCNZ_BIT]));

endmodule

//--- source/idecode_top.sv
// instruction decode stage, one byte per decode_en cycle in, registered exec_cmd out
// the source must stop presenting bytes while fetch_en is low

`include "idecode_params.svh"

module idecode_top (
    input  logic                        clk,
    input  logic                        reset_,
    input  logic                        decode_en,
    input  logic [`IDECODE_INST_W-1:0]  inst,
    input  logic [`IDECODE_CR_W-1:0]    sr,
    input  logic [`IDECODE_CR_W-1:0]    cr_wr_data,
    input  logic                        cr_wr_en,
    output idecode_pkg::exec_cmd_t      exec_cmd,
    output logic                        exec_en,
    output logic                        fetch_en,
    output logic                        latch_ret_addr,
    output logic [`IDECODE_ADDR_W-1:0]  tgt_addr,
    output logic [`IDECODE_CR_W-1:0]    cr
);
    import idecode_pkg::*;

    inst_u                      cur_inst;
    inst_u                      prev_inst;
    logic                       second_byte;
    logic                       first_byte;
    exec_op_t                   exec_op_next;
    exec_op_t                   exec_op_q;
    logic                       halted;
    logic                       branch_taken;
    bc_cmd_t                    bc_cmd;
    operand_sel_t               sel;
    logic [`IDECODE_INST_W-1:0] imm_val;
    logic                       imm_vld;
    logic [`IDECODE_ADDR_W-1:0] addr;

    decode_ctrl decode_ctrl_i (
        .clk, .reset_, .decode_en, .inst, .branch_taken,
        .cur_inst, .prev_inst, .second_byte, .first_byte, .exec_op_next,
        .exec_en, .fetch_en, .latch_ret_addr, .halted, .bc_cmd
    );

    operand_decode operand_decode_i (
        .clk, .reset_, .cur_inst, .prev_inst, .second_byte, .first_byte,
        .sel, .imm_val, .imm_vld
    );

    addr_assemble addr_assemble_i (
        .clk, .reset_, .cur_inst, .prev_inst, .second_byte,
        .addr, .tgt_addr
    );

    ctrl_reg ctrl_reg_i (
        .clk, .reset_, .cr_wr_data, .cr_wr_en, .bc_cmd, .sr,
        .cr, .branch_taken
    );

    // op stage, frozen once halted
    always_ff @(posedge clk) begin
        if (!reset_) begin
            exec_op_q <= EXEC_NOP;
        end else if (!halted) begin
            exec_op_q <= exec_op_next;
        end
    end

    always_comb begin
        exec_cmd.op         = exec_op_q;
        exec_cmd.src0       = sel.src0;
        exec_cmd.src0_rd_en = sel.src0_rd_en;
        exec_cmd.src1       = sel.src1;
        exec_cmd.src1_rd_en = sel.src1_rd_en;
        exec_cmd.dst        = sel.dst;
        exec_cmd.imm_val    = imm_val;
        exec_cmd.imm_vld    = imm_vld;
        exec_cmd.addr       = addr;
    end

endmodule

//--- verif/idecode_tb_table.svh
// stimulus rows for the decode stage testbench, included inside the testbench module
// line 1: de, inst, sr, cr_we, cr_wd
// line 2: en, op, src0, rd0, src1, rd1, dst, imm, vld, addr, fetch_en, cr, tgt_addr, latch

`ifndef IDECODE_TB_TABLE_SVH
`define IDECODE_TB_TABLE_SVH

localparam int NUM_ROWS = 24;

row_t rows [NUM_ROWS] = '{
    '{'{1'b1, 8'h27, 8'h00, 1'b0, 8'h00},   // ADD register form
      '{1'b1, EXEC_ADD, 2'd1, 1'b1, 2'd3, 1'b1, 2'd3, 8'h00, 1'b0, 12'h000, 1'b1, 8'h00, 12'h000, 1'b0}},
    '{'{1'b1, 8'hB6, 8'h00, 1'b0, 8'h00},   // XOR immediate
      '{1'b1, EXEC_XOR, 2'd1, 1'b1, 2'd3, 1'b0, 2'd2, 8'h00, 1'b0, 12'h000, 1'b1, 8'h00, 12'h000, 1'b0}},
    '{'{1'b1, 8'h5A, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd1, 1'b0, 2'd3, 1'b0, 2'd2, 8'h5A, 1'b1, 12'h000, 1'b1, 8'h00, 12'h000, 1'b0}},
    '{'{1'b1, 8'hCD, 8'h00, 1'b0, 8'h00},   // LD into r1
      '{1'b1, EXEC_MEM_RD, 2'd1, 1'b0, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b0, 12'h000, 1'b1, 8'h00, 12'h000, 1'b0}},
    '{'{1'b1, 8'h34, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd1, 1'b0, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b1, 12'h534, 1'b1, 8'h00, 12'h534, 1'b0}},
    '{'{1'b1, 8'hF6, 8'h00, 1'b0, 8'h00},   // ST from r2
      '{1'b1, EXEC_MEM_WR, 2'd2, 1'b1, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b0, 12'h534, 1'b1, 8'h00, 12'h534, 1'b0}},
    '{'{1'b1, 8'h12, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b1, 12'h612, 1'b1, 8'h00, 12'h612, 1'b0}},
    '{'{1'b1, 8'h03, 8'h00, 1'b0, 8'h00},   // SET_BCZ
      '{1'b1, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b0, 12'h612, 1'b1, 8'h01, 12'h612, 1'b0}},
    '{'{1'b1, 8'h12, 8'h00, 1'b0, 8'h00},   // JMP, Z clear, not taken
      '{1'b1, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h5A, 1'b0, 12'h612, 1'b1, 8'h01, 12'h612, 1'b0}},
    '{'{1'b1, 8'hAB, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'hAB, 1'b1, 12'h2AB, 1'b1, 8'h01, 12'h2AB, 1'b0}},
    '{'{1'b1, 8'h12, 8'h08, 1'b0, 8'h00},   // JMP, Z set, taken
      '{1'b1, EXEC_JMP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'hAB, 1'b0, 12'h2AB, 1'b1, 8'h01, 12'h2AB, 1'b0}},
    '{'{1'b1, 8'hCD, 8'h08, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'hCD, 1'b1, 12'h2CD, 1'b1, 8'h01, 12'h2CD, 1'b0}},
    '{'{1'b1, 8'h05, 8'h00, 1'b0, 8'h00},   // CLR_BC
      '{1'b1, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'hCD, 1'b0, 12'h2CD, 1'b1, 8'h00, 12'h2CD, 1'b0}},
    '{'{1'b1, 8'h11, 8'h00, 1'b0, 8'h00},   // unconditional JMP
      '{1'b1, EXEC_JMP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'hCD, 1'b0, 12'h2CD, 1'b1, 8'h00, 12'h2CD, 1'b0}},
    '{'{1'b1, 8'h22, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h22, 1'b1, 12'h122, 1'b1, 8'h00, 12'h122, 1'b0}},
    '{'{1'b1, 8'h1B, 8'h00, 1'b0, 8'h00},   // CALL
      '{1'b1, EXEC_CALL, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h22, 1'b0, 12'h122, 1'b1, 8'h00, 12'h122, 1'b1}},
    '{'{1'b1, 8'h40, 8'h00, 1'b0, 8'h00},
      '{1'b0, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h40, 1'b1, 12'h340, 1'b1, 8'h00, 12'h340, 1'b0}},
    '{'{1'b1, 8'h01, 8'h00, 1'b0, 8'h00},   // RET, window opens
      '{1'b1, EXEC_RET, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h40, 1'b0, 12'h340, 1'b0, 8'h00, 12'h340, 1'b0}},
    '{'{1'b1, 8'h27, 8'h00, 1'b0, 8'h00},   // taken as NOP
      '{1'b1, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h40, 1'b0, 12'h340, 1'b0, 8'h00, 12'h340, 1'b0}},
    '{'{1'b1, 8'h27, 8'h00, 1'b0, 8'h00},
      '{1'b1, EXEC_NOP, 2'd2, 1'b0, 2'd3, 1'b0, 2'd1, 8'h40, 1'b0, 12'h340, 1'b1, 8'h00, 12'h340, 1'b0}},
    '{'{1'b1, 8'h27, 8'h00, 1'b0, 8'h00},   // decoded again after the window
      '{1'b1, EXEC_ADD, 2'd1, 1'b1, 2'd3, 1'b1, 2'd3, 8'h40, 1'b0, 12'h340, 1'b1, 8'h00, 12'h340, 1'b0}},
    '{'{1'b0, 8'h00, 8'h00, 1'b1, 8'hA4},   // external cr write
      '{1'b0, EXEC_NOP, 2'd1, 1'b0, 2'd3, 1'b0, 2'd3, 8'h40, 1'b0, 12'h340, 1'b1, 8'hA4, 12'h340, 1'b0}},
    '{'{1'b1, 8'h02, 8'h00, 1'b0, 8'h00},   // HALT
      '{1'b0, EXEC_NOP, 2'd1, 1'b0, 2'd3, 1'b0, 2'd3, 8'h40, 1'b0, 12'h340, 1'b0, 8'hA4, 12'h340, 1'b0}},
    '{'{1'b1, 8'h27, 8'h00, 1'b0, 8'h00},   // ignored while halted
      '{1'b0, EXEC_NOP, 2'd1, 1'b0, 2'd3, 1'b0, 2'd3, 8'h40, 1'b0, 12'h340, 1'b0, 8'hA4, 12'h340, 1'b0}}
};

`endif

//--- verif/tb_idecode_top.sv
// testbench for the decode stage, applies the row table and checks every output
// registered fields are checked one cycle after the row that produced them

`include "idecode_params.svh"

module tb_idecode_top;
    timeunit 1ns;
    timeprecision 1ps;

    import idecode_pkg::*;

    typedef struct packed {
        logic                       de;
        logic [`IDECODE_INST_W-1:0] inst;
        logic [`IDECODE_CR_W-1:0]   sr;
        logic                       cr_we;
        logic [`IDECODE_CR_W-1:0]   cr_wd;
    } stim_t;

    typedef struct packed {
        logic                       en;
        exec_op_t                   op;
        logic [1:0]                 src0;
        logic                       src0_rd_en;
        logic [1:0]                 src1;
        logic                       src1_rd_en;
        logic [1:0]                 dst;
        logic [7:0]                 imm_val;
        logic                       imm_vld;
        logic [`IDECODE_ADDR_W-1:0] addr;
        logic                       fetch_en;
        logic [`IDECODE_CR_W-1:0]   cr;
        logic [`IDECODE_ADDR_W-1:0] tgt_addr;   // combinational, same cycle
        logic                       latch;      // combinational, same cycle
    } expect_t;

    typedef struct packed {
        stim_t   stim;
        expect_t exp;
    } row_t;

    `include "idecode_tb_table.svh"

    logic                       clk;
    logic                       reset_;
    logic                       decode_en;
    logic [`IDECODE_INST_W-1:0] inst;
    logic [`IDECODE_CR_W-1:0]   sr;
    logic [`IDECODE_CR_W-1:0]   cr_wr_data;
    logic                       cr_wr_en;
    exec_cmd_t                  exec_cmd;
    logic                       exec_en;
    logic                       fetch_en;
    logic                       latch_ret_addr;
    logic [`IDECODE_ADDR_W-1:0] tgt_addr;
    logic [`IDECODE_CR_W-1:0]   cr;

    int errors = 0;
    int checks = 0;
    int wait_cnt;

    idecode_top idecode_top_i (
        .clk, .reset_, .decode_en, .inst, .sr, .cr_wr_data, .cr_wr_en,
        .exec_cmd, .exec_en, .fetch_en, .latch_ret_addr, .tgt_addr, .cr
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // state after the edge that took the row
    task automatic check_regs(input expect_t e);
        check_val("exec_en", 32'(exec_en), 32'(e.en));
        check_val("exec_cmd.op", 32'(exec_cmd.op), 32'(e.op));
        check_val("exec_cmd.src0", 32'(exec_cmd.src0), 32'(e.src0));
        check_val("exec_cmd.src0_rd_en", 32'(exec_cmd.src0_rd_en), 32'(e.src0_rd_en));
        check_val("exec_cmd.src1", 32'(exec_cmd.src1), 32'(e.src1));
        check_val("exec_cmd.src1_rd_en", 32'(exec_cmd.src1_rd_en), 32'(e.src1_rd_en));
        check_val("exec_cmd.dst", 32'(exec_cmd.dst), 32'(e.dst));
        check_val("exec_cmd.imm_val", 32'(exec_cmd.imm_val), 32'(e.imm_val));
        check_val("exec_cmd.imm_vld", 32'(exec_cmd.imm_vld), 32'(e.imm_vld));
        check_val("exec_cmd.addr", 32'(exec_cmd.addr), 32'(e.addr));
        check_val("fetch_en", 32'(fetch_en), 32'(e.fetch_en));
        check_val("cr", 32'(cr), 32'(e.cr));
    endtask

    task automatic run_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            decode_en  <= rows[i].stim.de;
            inst       <= rows[i].stim.inst;
            sr         <= rows[i].stim.sr;
            cr_wr_en   <= rows[i].stim.cr_we;
            cr_wr_data <= rows[i].stim.cr_wd;
            @(negedge clk);
            if (i > 0) begin
                check_regs(rows[i-1].exp);
            end
            check_val("tgt_addr", 32'(tgt_addr), 32'(rows[i].exp.tgt_addr));
            check_val("latch_ret_addr", 32'(latch_ret_addr), 32'(rows[i].exp.latch));
        end
        @(posedge clk);
        decode_en <= 1'b0;
        cr_wr_en  <= 1'b0;
        @(negedge clk);
        check_regs(rows[NUM_ROWS-1].exp);
    endtask

    initial begin
        reset_     <= 1'b0;
        decode_en  <= 1'b0;
        inst       <= '0;
        sr         <= '0;
        cr_wr_data <= '0;
        cr_wr_en   <= 1'b0;
        repeat (16) @(posedge clk);
        reset_ <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!fetch_en && wait_cnt < 50) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!fetch_en) begin
            $display("timeout, fetch_en never rose after reset");
            $display("TEST FAIL");
            $finish;
        end else begin
            check_val("exec_en", 32'(exec_en), 32'd0);
            check_val("cr", 32'(cr), 32'(`IDECODE_CR_RESET));
            run_table();
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+source
+incdir+verif
source/idecode_pkg.sv
source/decode_ctrl.sv
source/operand_decode.sv
source/addr_assemble.sv
source/ctrl_reg.sv
source/idecode_top.sv
verif/tb_idecode_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the decode stage testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_idecode_top -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
else
    exit 1
fi
